// File: logic/nabp_pkg.sv
package nabp_pkg;

    // image and projection geometry
    localparam int IMAGE_SIZE = 16;
    localparam int SHIFT_CNT_W = 4;
    localparam int PROJ_LEN = 32;
    localparam int PROJ_ADDR_W = 5;
    localparam int SAMPLE_W = 8;

    // processing elements and the window positions they read
    localparam int NUM_PE = 4;
    localparam int PE_TAPS [NUM_PE] = '{0, 4, 8, 12};

    // fill runs from the last tap position down to 0
    localparam int FILL_CNT_INIT = 12;
    localparam int WINDOW_LEN = 13;

    // fixed-point accumulator, 4.6
    localparam int ACCU_INT_W = 4;
    localparam int ACCU_FRAC_W = 6;
    localparam int ACCU_W = 10;
    localparam logic [ACCU_W-1:0] ACCU_INIT = '0;

    localparam int SUM_W = 16;

    // state control encoding
    localparam int SC_STATE_W = 3;
    localparam logic [SC_STATE_W-1:0] SC_IDLE = 3'd0;
    localparam logic [SC_STATE_W-1:0] SC_FILL = 3'd1;
    localparam logic [SC_STATE_W-1:0] SC_WAIT_SHIFT = 3'd2;
    localparam logic [SC_STATE_W-1:0] SC_SHIFT = 3'd3;
    localparam logic [SC_STATE_W-1:0] SC_ACK = 3'd4;

    // shifter encoding
    localparam int SH_STATE_W = 2;
    localparam logic [SH_STATE_W-1:0] SH_READY = 2'd0;
    localparam logic [SH_STATE_W-1:0] SH_FILL = 2'd1;
    localparam logic [SH_STATE_W-1:0] SH_FILL_DONE = 2'd2;
    localparam logic [SH_STATE_W-1:0] SH_SHIFT = 2'd3;

    // raw view for wrapping adds, split view for floor compares
    typedef union packed {
        logic [ACCU_W-1:0] raw;
        struct packed {
            logic [ACCU_INT_W-1:0] whole;
            logic [ACCU_FRAC_W-1:0] frac;
        } fields;
    } accu_word_t;

endpackage

// File: logic/nabp_state_control.sv
`timescale 1ns/10ps

module nabp_state_control
(
    input  logic                 clk,
    input  logic                 reset_n,
    // angle request from the writer
    input  logic                 angle_req,
    input  nabp_pkg::accu_word_t angle_accu_base,
    output logic                 angle_ack,
    // shifter control
    output logic                 sc_fill_kick,
    output logic                 sc_shift_kick,
    output nabp_pkg::accu_word_t sc_accu_base,
    input  logic                 sc_fill_done,
    input  logic                 sc_shift_done
);

    logic [nabp_pkg::SC_STATE_W-1:0] state;
    logic [nabp_pkg::SC_STATE_W-1:0] next_state;
    logic                            fill_kick_q;
    nabp_pkg::accu_word_t            base_q;
    logic                            accept;

    // request only taken from idle, ack must have dropped before
    assign accept = (state == nabp_pkg::SC_IDLE) && angle_req;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::SC_IDLE;
            fill_kick_q <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // one-cycle kick right after acceptance
            fill_kick_q <= accept;
        end
    end

    // base is held for the whole angle
    always_ff @(posedge clk)
    begin
        if (accept)
            base_q <= angle_accu_base;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::SC_IDLE:
                if (angle_req)
                    next_state = nabp_pkg::SC_FILL;
            nabp_pkg::SC_FILL:
                if (sc_fill_done)
                    next_state = nabp_pkg::SC_WAIT_SHIFT;
            // single cycle, the shift kick goes out here
            nabp_pkg::SC_WAIT_SHIFT:
                next_state = nabp_pkg::SC_SHIFT;
            nabp_pkg::SC_SHIFT:
                if (sc_shift_done)
                    next_state = nabp_pkg::SC_ACK;
            nabp_pkg::SC_ACK:
                if (!angle_req)
                    next_state = nabp_pkg::SC_IDLE;
            default:
                next_state = nabp_pkg::SC_IDLE;
        endcase
    end

    assign sc_fill_kick = fill_kick_q;
    assign sc_shift_kick = (state == nabp_pkg::SC_WAIT_SHIFT);
    assign sc_accu_base = base_q;

    // held until the writer drops its request
    assign angle_ack = (state == nabp_pkg::SC_ACK);

endmodule

// File: logic/nabp_shifter.sv
`timescale 1ns/10ps

module nabp_shifter
(
    input  logic                 clk,
    input  logic                 reset_n,
    // from state control
    input  logic                 sc_fill_kick,
    input  logic                 sc_shift_kick,
    input  nabp_pkg::accu_word_t sc_accu_base,
    // to state control
    output logic                 sc_fill_done,
    output logic                 sc_shift_done,
    // to mapper
    output logic                 mp_kick,
    output logic                 mp_fill,
    output logic                 mp_shift_en,
    output logic                 mp_done
);

    logic [nabp_pkg::SH_STATE_W-1:0]  state;
    logic [nabp_pkg::SH_STATE_W-1:0]  next_state;
    logic [nabp_pkg::SHIFT_CNT_W-1:0] cnt;
    nabp_pkg::accu_word_t             accu;
    nabp_pkg::accu_word_t             accu_next;

    // wraps freely, only integer boundaries matter
    assign accu_next.raw = accu.raw + sc_accu_base.raw;

    assign mp_shift_en = (state == nabp_pkg::SH_FILL) ||
                         ((state == nabp_pkg::SH_SHIFT) &&
                          (accu_next.fields.whole != accu.fields.whole));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt <= nabp_pkg::SHIFT_CNT_W'(nabp_pkg::FILL_CNT_INIT);
            accu.raw <= nabp_pkg::ACCU_INIT;
        end
        else if (state == nabp_pkg::SH_FILL)
        begin
            if (cnt != '0)
                cnt <= cnt - 1'b1;
            else
                cnt <= nabp_pkg::SHIFT_CNT_W'(nabp_pkg::IMAGE_SIZE - 1);
        end
        else if (state == nabp_pkg::SH_SHIFT)
        begin
            // no add on the last step
            if (cnt != '0)
            begin
                cnt <= cnt - 1'b1;
                accu <= accu_next;
            end
            else
                cnt <= nabp_pkg::SHIFT_CNT_W'(nabp_pkg::FILL_CNT_INIT);
        end
        else if (state == nabp_pkg::SH_FILL_DONE)
        begin
            cnt <= nabp_pkg::SHIFT_CNT_W'(nabp_pkg::IMAGE_SIZE - 1);
            accu.raw <= nabp_pkg::ACCU_INIT;
        end
        else
        begin
            cnt <= nabp_pkg::SHIFT_CNT_W'(nabp_pkg::FILL_CNT_INIT);
            accu.raw <= nabp_pkg::ACCU_INIT;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::SH_READY;
        else
            state <= next_state;
    end

    // mealy outputs
    assign sc_fill_done = (state == nabp_pkg::SH_FILL) && (cnt == '0);
    assign sc_shift_done = (state == nabp_pkg::SH_SHIFT) && (cnt == '0);
    assign mp_kick = sc_fill_kick;
    assign mp_fill = (state == nabp_pkg::SH_FILL);
    assign mp_done = sc_shift_done;

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::SH_READY:
                if (sc_fill_kick)
                    next_state = nabp_pkg::SH_FILL;
            nabp_pkg::SH_FILL:
                if (sc_fill_done)
                    next_state = nabp_pkg::SH_FILL_DONE;
            nabp_pkg::SH_FILL_DONE:
                if (sc_shift_kick)
                    next_state = nabp_pkg::SH_SHIFT;
            default:
                if (sc_shift_done)
                    next_state = nabp_pkg::SH_READY;
        endcase
    end

endmodule

// File: logic/nabp_filter_mapper.sv
`timescale 1ns/10ps

module nabp_filter_mapper
(
    input  logic                             clk,
    input  logic                             reset_n,
    // projection buffer write port
    input  logic                             sample_wr_en,
    input  logic [nabp_pkg::PROJ_ADDR_W-1:0] sample_wr_addr,
    input  logic [nabp_pkg::SAMPLE_W-1:0]    sample_wr_data,
    // from shifter
    input  logic                             mp_kick,
    input  logic                             mp_fill,
    input  logic                             mp_shift_en,
    input  logic                             mp_done,
    // to processing elements
    output logic                             pixel_valid,
    output logic [nabp_pkg::SHIFT_CNT_W-1:0] pixel_index,
    output logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_0,
    output logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_1,
    output logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_2,
    output logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_3
);

    logic [nabp_pkg::SAMPLE_W-1:0]    proj_buf [nabp_pkg::PROJ_LEN];
    logic [nabp_pkg::SAMPLE_W-1:0]    window [nabp_pkg::WINDOW_LEN];
    // one extra bit so reads past the line end are seen
    logic [nabp_pkg::PROJ_ADDR_W:0]   rd_addr;
    logic [nabp_pkg::SAMPLE_W-1:0]    rd_word;
    logic [nabp_pkg::SHIFT_CNT_W-1:0] step_cnt;
    logic                             fill_q;
    logic                             in_shift;

    always_ff @(posedge clk)
    begin
        if (sample_wr_en)
            proj_buf[sample_wr_addr] <= sample_wr_data;
    end

    // beyond the last sample the line is zero
    assign rd_word = rd_addr[nabp_pkg::PROJ_ADDR_W] ? '0 :
                     proj_buf[rd_addr[nabp_pkg::PROJ_ADDR_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_addr <= '0;
        else if (mp_kick)
            rd_addr <= '0;
        else if (mp_shift_en)
            rd_addr <= rd_addr + 1'b1;
    end

    // window moves toward position 0, new word enters at the top
    always_ff @(posedge clk)
    begin
        if (mp_shift_en)
        begin
            for (int j = 0; j < nabp_pkg::WINDOW_LEN - 1; j++)
                window[j] <= window[j + 1];
            window[nabp_pkg::WINDOW_LEN - 1] <= rd_word;
        end
    end

    // shift kick always comes one cycle after fill ends,
    // so the phase starts two cycles after the fill falls
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_q <= 1'b0;
            in_shift <= 1'b0;
            step_cnt <= '0;
        end
        else
        begin
            fill_q <= mp_fill;
            if (fill_q && !mp_fill)
                in_shift <= 1'b1;
            else if (mp_done)
                in_shift <= 1'b0;
            if (mp_fill)
                step_cnt <= '0;
            else if (in_shift)
                step_cnt <= step_cnt + 1'b1;
        end
    end

    assign pixel_valid = in_shift;
    assign pixel_index = step_cnt;

    // taps show the window before this cycle's shift
    assign tap_data_0 = window[nabp_pkg::PE_TAPS[0]];
    assign tap_data_1 = window[nabp_pkg::PE_TAPS[1]];
    assign tap_data_2 = window[nabp_pkg::PE_TAPS[2]];
    assign tap_data_3 = window[nabp_pkg::PE_TAPS[3]];

endmodule

// File: logic/nabp_pe_array.sv
`timescale 1ns/10ps

module nabp_pe_array
(
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  clear,
    // from mapper
    input  logic                                  pixel_valid,
    input  logic [nabp_pkg::SHIFT_CNT_W-1:0]      pixel_index,
    input  logic [nabp_pkg::SAMPLE_W-1:0]         tap_data_0,
    input  logic [nabp_pkg::SAMPLE_W-1:0]         tap_data_1,
    input  logic [nabp_pkg::SAMPLE_W-1:0]         tap_data_2,
    input  logic [nabp_pkg::SAMPLE_W-1:0]         tap_data_3,
    // sum read port
    input  logic [$clog2(nabp_pkg::NUM_PE)-1:0]   rd_pe,
    input  logic [nabp_pkg::SHIFT_CNT_W-1:0]      rd_pixel,
    output logic [nabp_pkg::SUM_W-1:0]            rd_data
);

    logic [nabp_pkg::SUM_W-1:0]    sums [nabp_pkg::NUM_PE][nabp_pkg::IMAGE_SIZE];
    logic [nabp_pkg::SAMPLE_W-1:0] taps [nabp_pkg::NUM_PE];

    assign taps[0] = tap_data_0;
    assign taps[1] = tap_data_1;
    assign taps[2] = tap_data_2;
    assign taps[3] = tap_data_3;

    // each PE owns one row of pixel sums
    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
        begin
            for (int p = 0; p < nabp_pkg::NUM_PE; p++)
            begin
                for (int i = 0; i < nabp_pkg::IMAGE_SIZE; i++)
                    sums[p][i] <= '0;
            end
        end
        else if (pixel_valid)
        begin
            // sums wrap at SUM_W bits
            for (int p = 0; p < nabp_pkg::NUM_PE; p++)
                sums[p][pixel_index] <= sums[p][pixel_index] +
                                        nabp_pkg::SUM_W'(taps[p]);
        end
    end

    // combinational read
    assign rd_data = sums[rd_pe][rd_pixel];

endmodule

// File: logic/nabp_top.sv
`timescale 1ns/10ps

module nabp_top
(
    input  logic                                clk,
    input  logic                                reset_n,
    // angle handshake
    input  logic                                angle_req,
    input  nabp_pkg::accu_word_t                angle_accu_base,
    output logic                                angle_ack,
    // projection buffer writes
    input  logic                                sample_wr_en,
    input  logic [nabp_pkg::PROJ_ADDR_W-1:0]    sample_wr_addr,
    input  logic [nabp_pkg::SAMPLE_W-1:0]       sample_wr_data,
    // sums
    input  logic                                clear,
    input  logic [$clog2(nabp_pkg::NUM_PE)-1:0] rd_pe,
    input  logic [nabp_pkg::SHIFT_CNT_W-1:0]    rd_pixel,
    output logic [nabp_pkg::SUM_W-1:0]          rd_data
);

    logic                             sc_fill_kick;
    logic                             sc_shift_kick;
    nabp_pkg::accu_word_t             sc_accu_base;
    logic                             sc_fill_done;
    logic                             sc_shift_done;
    logic                             mp_kick;
    logic                             mp_fill;
    logic                             mp_shift_en;
    logic                             mp_done;
    logic                             pixel_valid;
    logic [nabp_pkg::SHIFT_CNT_W-1:0] pixel_index;
    logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_0;
    logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_1;
    logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_2;
    logic [nabp_pkg::SAMPLE_W-1:0]    tap_data_3;

    nabp_state_control u_state_control (.*);

    nabp_shifter u_shifter (.*);

    nabp_filter_mapper u_filter_mapper (.*);

    nabp_pe_array u_pe_array (.*);

endmodule

// File: verif/nabp_tb.sv
`timescale 1ns/10ps

module nabp_tb;

    localparam int unsigned SEED = 32'hd6640e5a;
    localparam int RESET_CYCLES = 10;
    localparam int ACK_LATENCY = 32;
    localparam int ACK_LIMIT = 2 * ACK_LATENCY;
    localparam int PE_SEL_W = $clog2(nabp_pkg::NUM_PE);
    // 1.0 in the 4.6 format
    localparam int ONE_STEP = 1 << nabp_pkg::ACCU_FRAC_W;
    localparam int FRAC_ANGLES = 8;
    localparam int ACCU_ANGLES = 3;
    // angles of the integer step, the fractional set, the accumulation and the one after clear
    localparam int ANGLE_CNT = 1 + FRAC_ANGLES + ACCU_ANGLES + 1;
    localparam int READOUT_CNT = 1 + 1 + FRAC_ANGLES + 3;
    localparam int WRITE_CYCLES = nabp_pkg::PROJ_LEN + 8;
    localparam int READ_CYCLES = READOUT_CNT * nabp_pkg::NUM_PE * nabp_pkg::IMAGE_SIZE;
    localparam int WATCH_CYCLES = (ANGLE_CNT * ACK_LATENCY + WRITE_CYCLES + READ_CYCLES) * 2
                                  + RESET_CYCLES;

    logic                                clk;
    logic                                reset_n;
    logic                                angle_req;
    nabp_pkg::accu_word_t                angle_accu_base;
    logic                                angle_ack;
    logic                                sample_wr_en;
    logic [nabp_pkg::PROJ_ADDR_W-1:0]    sample_wr_addr;
    logic [nabp_pkg::SAMPLE_W-1:0]       sample_wr_data;
    logic                                clear;
    logic [PE_SEL_W-1:0]                 rd_pe;
    logic [nabp_pkg::SHIFT_CNT_W-1:0]    rd_pixel;
    logic [nabp_pkg::SUM_W-1:0]          rd_data;

    // reference copies of the buffer and the sums
    logic [nabp_pkg::SAMPLE_W-1:0] samples [nabp_pkg::PROJ_LEN];
    logic [nabp_pkg::SUM_W-1:0]    exp_sum [nabp_pkg::NUM_PE][nabp_pkg::IMAGE_SIZE];

    nabp_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string test_name, input int unsigned expected,
                               input int unsigned actual);
        stop_on_error($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
                                test_name, expected, actual));
    endtask

    // handshake rules checked on every clock
    assert property (@(posedge clk) disable iff (!reset_n)
                     (angle_ack && angle_req) |=> angle_ack)
        else stop_on_error("angle_ack fell while angle_req was still high");

    assert property (@(posedge clk) disable iff (!reset_n)
                     (angle_ack && !angle_req) |=> !angle_ack)
        else stop_on_error("angle_ack stayed high after angle_req fell");

    initial
    begin
        repeat (WATCH_CYCLES) @(posedge clk);
        stop_on_error("watchdog expired before the tests finished");
    end

    // addresses past the line read as zero
    function automatic logic [nabp_pkg::SAMPLE_W-1:0] sample_at(input int addr);
        if (addr < nabp_pkg::PROJ_LEN)
            return samples[addr];
        return '0;
    endfunction

    task automatic zero_model();
        for (int p = 0; p < nabp_pkg::NUM_PE; p++)
            for (int i = 0; i < nabp_pkg::IMAGE_SIZE; i++)
                exp_sum[p][i] = '0;
    endtask

    // o counts window shifts taken before step k
    task automatic model_angle(input int base);
        int o;
        int whole_now;
        int whole_next;
        o = 0;
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            for (int j = 0; j < nabp_pkg::NUM_PE; j++)
                exp_sum[j][k] = exp_sum[j][k] +
                                nabp_pkg::SUM_W'(sample_at(o + nabp_pkg::PE_TAPS[j]));
            whole_now = ((k * base) >> nabp_pkg::ACCU_FRAC_W) % (1 << nabp_pkg::ACCU_INT_W);
            whole_next = (((k + 1) * base) >> nabp_pkg::ACCU_FRAC_W) %
                         (1 << nabp_pkg::ACCU_INT_W);
            if (whole_next != whole_now)
                o++;
        end
    endtask

    task automatic load_samples();
        for (int a = 0; a < nabp_pkg::PROJ_LEN; a++)
        begin
            @(negedge clk);
            sample_wr_en = 1'b1;
            sample_wr_addr = nabp_pkg::PROJ_ADDR_W'(a);
            sample_wr_data = nabp_pkg::SAMPLE_W'($urandom);
            samples[a] = sample_wr_data;
        end
        @(negedge clk);
        sample_wr_en = 1'b0;
    endtask

    task automatic clear_sums();
        @(negedge clk);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        zero_model();
    endtask

    // four-phase request with ack latency counted in clocks
    task automatic run_angle(input int base);
        int cycles;
        int hold;
        cycles = 0;
        @(negedge clk);
        angle_accu_base.raw = nabp_pkg::ACCU_W'(base);
        angle_req = 1'b1;
        while (!angle_ack && cycles < ACK_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (angle_ack)
            else stop_on_error("angle_ack never rose after angle_req");
        assert (cycles == ACK_LATENCY)
            else value_error("ack_latency", ACK_LATENCY, cycles);
        // request held at least one more cycle so ack is seen holding
        hold = 1 + $urandom % 3;
        repeat (hold) @(negedge clk);
        angle_req = 1'b0;
        @(negedge clk);
        assert (!angle_ack)
            else stop_on_error("angle_ack still high one cycle after angle_req fell");
    endtask

    task automatic check_sums(input string test_name);
        for (int p = 0; p < nabp_pkg::NUM_PE; p++)
        begin
            for (int i = 0; i < nabp_pkg::IMAGE_SIZE; i++)
            begin
                @(negedge clk);
                rd_pe = PE_SEL_W'(p);
                rd_pixel = nabp_pkg::SHIFT_CNT_W'(i);
                @(posedge clk);
                assert (rd_data == exp_sum[p][i])
                    else value_error($sformatf("%s pe%0d pixel%0d", test_name, p, i),
                                     32'(exp_sum[p][i]), 32'(rd_data));
            end
        end
    endtask

    initial
    begin
        int base;
        int frac_bases [FRAC_ANGLES];
        void'($urandom(SEED));
        reset_n = 1'b0;
        angle_req = 1'b0;
        angle_accu_base.raw = '0;
        sample_wr_en = 1'b0;
        sample_wr_addr = '0;
        sample_wr_data = '0;
        clear = 1'b0;
        rd_pe = '0;
        rd_pixel = '0;
        zero_model();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        assert (!angle_ack)
            else value_error("reset_ack", 0, 32'(angle_ack));
        check_sums("reset");

        load_samples();

        // base of 1.0 moves the window on every step
        run_angle(ONE_STEP);
        for (int j = 0; j < nabp_pkg::NUM_PE; j++)
            for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
                exp_sum[j][k] = nabp_pkg::SUM_W'(sample_at(k + nabp_pkg::PE_TAPS[j]));
        check_sums("integer_step");

        // zero, two just below 1.0 and one just below 16.0 before the random ones
        frac_bases[0] = 0;
        frac_bases[1] = ONE_STEP - 1;
        frac_bases[2] = ONE_STEP - 2;
        frac_bases[3] = (1 << nabp_pkg::ACCU_W) - 1;
        for (int t = 4; t < FRAC_ANGLES; t++)
            frac_bases[t] = $urandom % (1 << nabp_pkg::ACCU_W);
        for (int t = 0; t < FRAC_ANGLES; t++)
        begin
            clear_sums();
            run_angle(frac_bases[t]);
            model_angle(frac_bases[t]);
            check_sums($sformatf("frac_base_%0h", frac_bases[t]));
        end

        // several angles summed into one image
        clear_sums();
        for (int t = 0; t < ACCU_ANGLES; t++)
        begin
            base = t * 300 + $urandom % 300;
            run_angle(base);
            model_angle(base);
        end
        check_sums("accumulate");

        clear_sums();
        check_sums("clear");

        base = $urandom % (1 << nabp_pkg::ACCU_W);
        run_angle(base);
        model_angle(base);
        check_sums("after_clear");

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: vlog.f
logic/nabp_pkg.sv
logic/nabp_state_control.sv
logic/nabp_shifter.sv
logic/nabp_filter_mapper.sv
logic/nabp_pe_array.sv
logic/nabp_top.sv
verif/nabp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the back-projection shift stage with Verilator and runs the testbench

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=nabp_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module nabp_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q ">>> FAIL" "$LOG_FILE"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG_FILE"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
